// File: Makefile
VERILATOR ?= verilator
TOP       ?= rvseed_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/rvseed_assertions.sv
// rvseed pipeline checks
`timescale 1ns/100ps
`include "rvseed_settings.svh"

module rvseed_assertions (
    input logic                          clk,
    input logic                          rst_n_i,
    input logic                          retire_valid_i,
    input logic [`CPU_WIDTH-1:0]         retire_pc_i,
    input logic                          halted_i,
    input logic                          redirect_i,
    input logic [`CPU_WIDTH-1:0]         next_pc_i,
    input rvseed_pipe_pkg::fetch_state_e fetch_state_i
);

    int                    err_count = 0;
    logic                  red_ex, red_wb, last_red, have_last;
    logic [`CPU_WIDTH-1:0] tgt_ex, tgt_wb, last_tgt, last_pc;

    // carry the decode redirect along with its instruction to retirement
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            red_ex    <= 1'b0;
            red_wb    <= 1'b0;
            have_last <= 1'b0;
            last_red  <= 1'b0;
        end else begin
            red_ex <= redirect_i;
            tgt_ex <= next_pc_i;
            red_wb <= red_ex;
            tgt_wb <= tgt_ex;
            if (retire_valid_i) begin
                have_last <= 1'b1;
                last_red  <= red_wb;
                last_tgt  <= tgt_wb;
                last_pc   <= retire_pc_i;
            end
        end
    end

    pc_order: assert property (@(posedge clk) disable iff (!rst_n_i)
        retire_valid_i && have_last |-> retire_pc_i == (last_red ? last_tgt : last_pc + 64'd4))
        else begin
            err_count <= err_count + 1;
            $error("retired pc out of program order");
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
        halted_i |=> halted_i && !retire_valid_i)
        else begin
            err_count <= err_count + 1;
            $error("retirement after halt");
        end

    // the ebreak reached fetch control before it retired
    halt_stops_fetch: assert property (@(posedge clk) disable iff (!rst_n_i)
        halted_i |-> fetch_state_i == rvseed_pipe_pkg::HALTED)
        else begin
            err_count <= err_count + 1;
            $error("fetch still running after halt");
        end

    quiet_reset: assert property (@(posedge clk)
        !rst_n_i || !$past(rst_n_i) |-> !retire_valid_i && !halted_i)
        else begin
            err_count <= err_count + 1;
            $error("activity during reset");
        end

endmodule

// File: tests/rvseed_tb.sv
// rvseed pipeline testbench
`timescale 1ns/100ps
`include "rvseed_settings.svh"

module rvseed_tb;

    localparam int PROG_LEN   = 249;
    localparam int RETIRE_LEN = 244;  // five wrong-path words never retire

    logic                       clk, rst_n_i, retire_valid_o, retire_wen_o, unknown_o, halted_o;
    logic [31:0]                imem_data_i, unknown_code_o;
    logic [`CPU_WIDTH-1:0]      imem_addr_o, retire_pc_o, retire_data_o, exp_pc;
    logic [`REG_ADDR_WIDTH-1:0] retire_rd_o;
    logic [31:0]                imem [0:511];
    logic [`CPU_WIDTH-1:0]      gold [0:`REG_DATA_DEPTH-1];
    logic                       saw_ebreak = 1'b0;
    int                         retired = 0;

    rvseed_top dut (.*);

    bind rvseed_top rvseed_assertions chk (
        .clk(clk), .rst_n_i(rst_n_i), .retire_valid_i(retire_valid_o),
        .retire_pc_i(retire_pc_o), .halted_i(halted_o), .redirect_i(redirect),
        .next_pc_i(next_pc), .fetch_state_i(u_if_stage.state_r)
    );

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd);
        return {imm, rs1, f3, rd, rvseed_isa_pkg::OP_IMM};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rvseed_isa_pkg::OP};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvseed_isa_pkg::BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvseed_isa_pkg::JAL};
    endfunction

    // sources lean on the last two destinations to hit both bypass paths
    function automatic logic [31:0] rand_alu(logic [4:0] prev1, logic [4:0] prev2);
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm;
        int          kind;
        kind = $urandom_range(11, 0);
        rd   = 5'($urandom);
        rs1  = ($urandom_range(2, 0) != 0) ? prev1 : 5'($urandom);
        rs2  = ($urandom_range(2, 0) != 0) ? prev2 : 5'($urandom);
        imm  = 12'($urandom);
        case (kind)
            0:       return enc_i(imm, rs1, 3'b000, rd);
            1:       return enc_i(imm, rs1, 3'b111, rd);
            2:       return enc_i(imm, rs1, 3'b110, rd);
            3:       return enc_i(imm, rs1, 3'b100, rd);
            4:       return enc_i({6'b0, imm[5:0]}, rs1, 3'b001, rd);
            5:       return enc_i({6'b0, imm[5:0]}, rs1, 3'b101, rd);
            6:       return enc_r(7'b0000000, rs2, rs1, 3'b000, rd);
            7:       return enc_r(7'b0100000, rs2, rs1, 3'b000, rd);
            8:       return enc_r(7'b0000000, rs2, rs1, 3'b111, rd);
            9:       return enc_r(7'b0000000, rs2, rs1, 3'b110, rd);
            10:      return enc_r(7'b0000000, rs2, rs1, 3'b100, rd);
            default: return {imm, 8'($urandom), rd, rvseed_isa_pkg::LUI};
        endcase
    endfunction

    task automatic build_program();
        logic [31:0] fixed [0:17];
        for (int i = 0; i < 512; i++)
            imem[i] = enc_i(12'(i), 5'd0, 3'b000, 5'd0);  // addi x0 with the word index
        for (int i = 0; i < 31; i++)
            imem[i] = enc_i(12'($urandom), 5'd0, 3'b000, 5'(i + 1));
        for (int i = 31; i < 231; i++)
            imem[i] = rand_alu(imem[i-1][11:7], imem[i-2][11:7]);
        fixed = '{enc_b(13'd8, 5'd0, 5'd0, 3'b000), enc_i(12'd1, 5'd0, 3'b000, 5'd1),
                  enc_b(13'd8, 5'd1, 5'd1, 3'b001), enc_i(12'd7, 5'd0, 3'b000, 5'd5),
                  enc_i(12'd7, 5'd0, 3'b000, 5'd6), enc_b(13'd8, 5'd6, 5'd5, 3'b000),
                  enc_i(12'd99, 5'd0, 3'b000, 5'd5), enc_b(13'd8, 5'd0, 5'd5, 3'b001),
                  enc_i(12'd1, 5'd0, 3'b000, 5'd6), enc_j(21'd8, 5'd1),
                  enc_i(12'd5, 5'd0, 3'b000, 5'd1), enc_j(21'd8, 5'd0),
                  enc_i(12'd5, 5'd0, 3'b000, 5'd2), enc_i(12'd0, 5'd1, 3'b000, 5'd2),
                  enc_r(7'b0, 5'd0, 5'd0, 3'b000, 5'd7), 32'h0123_4000,
                  enc_i(12'd1, 5'd3, 3'b000, 5'd3), 32'h0010_0073};
        for (int i = 0; i < 18; i++)
            imem[231+i] = fixed[i];
    endtask

    // reference behavior of one instruction from the RV64I rules
    task automatic predict(input logic [31:0] inst, input logic [63:0] pc,
                           output logic [63:0] res, output logic wen, output logic unk,
                           output logic brk, output logic [63:0] nxt);
        logic [63:0] a, b, imm;
        a   = (inst[19:15] == 0) ? 64'd0 : gold[inst[19:15]];
        b   = (inst[24:20] == 0) ? 64'd0 : gold[inst[24:20]];
        imm = {{52{inst[31]}}, inst[31:20]};
        {res, wen, unk, brk, nxt} = {64'd0, 3'b100, pc + 64'd4};
        case (inst[6:0])
            rvseed_isa_pkg::OP_IMM: case (inst[14:12])
                3'b000: res = a + imm;
                3'b111: res = a & imm;
                3'b110: res = a | imm;
                3'b100: res = a ^ imm;
                3'b001: res = a << inst[25:20];
                3'b101: res = a >> inst[25:20];
                default: unk = 1'b1;
            endcase
            rvseed_isa_pkg::OP: case ({inst[31:25], inst[14:12]})
                10'b0000000_000: res = a + b;
                10'b0100000_000: res = a - b;
                10'b0000000_111: res = a & b;
                10'b0000000_110: res = a | b;
                10'b0000000_100: res = a ^ b;
                default:         unk = 1'b1;
            endcase
            rvseed_isa_pkg::LUI: res = {{32{inst[31]}}, inst[31:12], 12'b0};
            rvseed_isa_pkg::BRANCH: begin
                wen = 1'b0;
                unk = inst[14:13] != 2'b00;
                if (!unk && ((a == b) ^ inst[12]))
                    nxt = pc + {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            rvseed_isa_pkg::JAL: begin
                res = pc + 64'd4;
                nxt = pc + {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                brk = (inst == 32'h0010_0073);
                unk = !brk;
                wen = 1'b0;
            end
        endcase
        if (unk)
            wen = 1'b0;  // retired as a no-op
    endtask

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_with_failure("retired value differs from the register model");
        end
    endtask

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // word read 0.5 ns after the edge that moves the PC
    always @(posedge clk) begin
        #0.5;
        imem_data_i = imem[imem_addr_o[10:2]];
    end

    always @(negedge clk) begin
        logic [63:0] res, nxt;
        logic [31:0] inst;
        logic [4:0]  rd;
        logic        wen, unk, brk;
        if (dut.chk.err_count != 0)
            stop_with_failure("a pipeline assertion failed");
        if (rst_n_i && retire_valid_o) begin
            check("retire_pc_o", retire_pc_o, exp_pc);
            inst = imem[exp_pc[10:2]];
            rd   = inst[11:7];
            predict(inst, exp_pc, res, wen, unk, brk, nxt);
            check("unknown_o", 64'(unknown_o), 64'(unk));
            if (unk)
                check("unknown_code_o", 64'(unknown_code_o), 64'(inst));
            check("retire_wen_o", 64'(retire_wen_o), 64'(wen && rd != 0));
            if (wen && rd != 0) begin
                check("retire_rd_o", 64'(retire_rd_o), 64'(rd));
                check("retire_data_o", retire_data_o, res);
                gold[rd] = res;
            end
            if (brk)
                saw_ebreak = 1'b1;
            exp_pc  = nxt;
            retired = retired + 1;
        end
    end

    initial begin
        repeat (8 + 4 * PROG_LEN) @(posedge clk);
        stop_with_failure("timeout, the core never halted");
    end

    initial begin
        rst_n_i     = 1'b0;
        imem_data_i = '0;
        exp_pc      = `RESET_PC;
        void'($urandom(32'he5c9_a5c4));
        build_program();
        foreach (gold[i])
            gold[i] = '0;
        repeat (8) @(posedge clk);
        #0.5 rst_n_i = 1'b1;
        while (!halted_o)
            @(posedge clk);
        repeat (10) @(posedge clk);
        if (dut.chk.err_count == 0 && saw_ebreak && retired == RETIRE_LEN) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_with_failure($sformatf("halted with %0d of %0d instructions retired",
                                        retired, RETIRE_LEN));
        end
    end

endmodule

// File: verilog/ex_stage.sv
// rvseed execute stage ALU
`timescale 1ns/100ps
`include "rvseed_settings.svh"

module ex_stage (
    input  rvseed_isa_pkg::alu_op_e alu_op_i,
    input  logic [`CPU_WIDTH-1:0]   src1_i,
    input  logic [`CPU_WIDTH-1:0]   src2_i,
    output logic [`CPU_WIDTH-1:0]   result_o
);

    logic [5:0] shamt;

    assign shamt = src2_i[5:0];  // rv64 shifts use six bits

    always_comb begin
        case (alu_op_i)
            rvseed_isa_pkg::ADD:    result_o = src1_i + src2_i;
            rvseed_isa_pkg::SUB:    result_o = src1_i - src2_i;
            rvseed_isa_pkg::AND:    result_o = src1_i & src2_i;
            rvseed_isa_pkg::OR:     result_o = src1_i | src2_i;
            rvseed_isa_pkg::XOR:    result_o = src1_i ^ src2_i;
            rvseed_isa_pkg::SLL:    result_o = src1_i << shamt;
            rvseed_isa_pkg::SRL:    result_o = src1_i >> shamt;  // logical
            rvseed_isa_pkg::PASS_B: result_o = src2_i;
            default:                result_o = '0;
        endcase
    end

endmodule

// File: verilog/id_ex_regs.sv
// rvseed decode to execute register
`timescale 1ns/100ps
`include "rvseed_settings.svh"

module id_ex_regs (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       valid_i,
    input  logic [`CPU_WIDTH-1:0]      pc_i,
    input  rvseed_isa_pkg::alu_op_e    alu_op_i,
    input  logic [`CPU_WIDTH-1:0]      src1_i,
    input  logic [`CPU_WIDTH-1:0]      src2_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rd_i,
    input  logic                       wen_i,
    input  logic                       ebreak_i,
    input  logic                       unknown_i,
    input  logic [31:0]                inst_i,
    output logic                       valid_o,
    output logic [`CPU_WIDTH-1:0]      pc_o,
    output rvseed_isa_pkg::alu_op_e    alu_op_o,
    output logic [`CPU_WIDTH-1:0]      src1_o,
    output logic [`CPU_WIDTH-1:0]      src2_o,
    output logic [`REG_ADDR_WIDTH-1:0] rd_o,
    output logic                       wen_o,
    output logic                       ebreak_o,
    output logic                       unknown_o,
    output logic [31:0]                inst_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            valid_o <= 1'b0;
        else
            valid_o <= valid_i;
    end

    // flags below only count while valid_o is high
    always_ff @(posedge clk) begin
        pc_o      <= pc_i;
        alu_op_o  <= alu_op_i;
        src1_o    <= src1_i;
        src2_o    <= src2_i;
        rd_o      <= rd_i;
        wen_o     <= wen_i;
        ebreak_o  <= ebreak_i;
        unknown_o <= unknown_i;
        inst_o    <= inst_i;  // kept for the unknown code report
    end

endmodule

// File: verilog/id_stage.sv
// rvseed decode stage
`timescale 1ns/100ps
`include "rvseed_settings.svh"

module id_stage (
    input  logic [`CPU_WIDTH-1:0]     pc_i,
    input  logic [31:0]               inst_i,
    input  logic                      valid_i,
    input  logic                      ex_valid_i,
    input  logic                      ex_wen_i,
    input  logic [`REG_ADDR_WIDTH-1:0] ex_rd_i,
    input  logic [`CPU_WIDTH-1:0]     ex_result_i,
    input  logic                      wb_valid_i,
    input  logic                      wb_wen_i,
    input  logic [`REG_ADDR_WIDTH-1:0] wb_rd_i,
    input  logic [`CPU_WIDTH-1:0]     wb_data_i,
    input  logic [`CPU_WIDTH-1:0]     rf_rdata1_i,
    input  logic [`CPU_WIDTH-1:0]     rf_rdata2_i,
    output logic [`REG_ADDR_WIDTH-1:0] rf_raddr1_o,
    output logic [`REG_ADDR_WIDTH-1:0] rf_raddr2_o,
    output rvseed_isa_pkg::alu_op_e   alu_op_o,
    output logic [`CPU_WIDTH-1:0]     src1_o,
    output logic [`CPU_WIDTH-1:0]     src2_o,
    output logic [`REG_ADDR_WIDTH-1:0] rd_o,
    output logic                      wen_o,
    output logic                      valid_o,
    output logic                      ebreak_o,
    output logic                      unknown_o,
    output logic                      redirect_o,
    output logic [`CPU_WIDTH-1:0]     next_pc_o,
    output logic                      halt_req_o
);

    rvseed_isa_pkg::opcode_e    opcode;
    rvseed_pipe_pkg::bypass_e   sel1, sel2;
    logic [`REG_ADDR_WIDTH-1:0] rs1, rs2;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic [`CPU_WIDTH-1:0]      imm_i, imm_u, imm_b, imm_j;
    logic [`CPU_WIDTH-1:0]      rs1_val, rs2_val;
    logic                       is_branch, is_jal, taken;

    // youngest producer wins
    function automatic rvseed_pipe_pkg::bypass_e bypass_sel(
        input logic ex_hit,
        input logic wb_hit
    );
        if (ex_hit)
            return rvseed_pipe_pkg::FROM_EX;
        if (wb_hit)
            return rvseed_pipe_pkg::FROM_WB;
        return rvseed_pipe_pkg::REGFILE;
    endfunction

    function automatic logic [`CPU_WIDTH-1:0] operand(
        input rvseed_pipe_pkg::bypass_e   sel,
        input logic [`REG_ADDR_WIDTH-1:0] rs,
        input logic [`CPU_WIDTH-1:0]      ex_val,
        input logic [`CPU_WIDTH-1:0]      wb_val,
        input logic [`CPU_WIDTH-1:0]      rf_val
    );
        if (rs == '0)
            return '0;  // x0 reads zero whatever is in flight
        case (sel)
            rvseed_pipe_pkg::FROM_EX: return ex_val;
            rvseed_pipe_pkg::FROM_WB: return wb_val;
            default:                  return rf_val;
        endcase
    endfunction

    assign opcode = rvseed_isa_pkg::opcode_e'(inst_i[6:0]);
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign imm_i  = {{(`CPU_WIDTH-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u  = {{(`CPU_WIDTH-32){inst_i[31]}}, inst_i[31:12], 12'b0};
    assign imm_b  = {{(`CPU_WIDTH-13){inst_i[31]}}, inst_i[31], inst_i[7],
                     inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j  = {{(`CPU_WIDTH-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                     inst_i[20], inst_i[30:21], 1'b0};

    assign sel1 = bypass_sel(ex_valid_i && ex_wen_i && ex_rd_i == rs1,
                             wb_valid_i && wb_wen_i && wb_rd_i == rs1);
    assign sel2 = bypass_sel(ex_valid_i && ex_wen_i && ex_rd_i == rs2,
                             wb_valid_i && wb_wen_i && wb_rd_i == rs2);
    assign rs1_val = operand(sel1, rs1, ex_result_i, wb_data_i, rf_rdata1_i);
    assign rs2_val = operand(sel2, rs2, ex_result_i, wb_data_i, rf_rdata2_i);

    always_comb begin
        alu_op_o  = rvseed_isa_pkg::ADD;
        src2_o    = rs2_val;
        wen_o     = 1'b0;
        ebreak_o  = 1'b0;
        unknown_o = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        case (opcode)
            rvseed_isa_pkg::OP_IMM: begin
                src2_o = imm_i;
                wen_o  = 1'b1;
                case (funct3)
                    3'b000:  alu_op_o = rvseed_isa_pkg::ADD;
                    3'b111:  alu_op_o = rvseed_isa_pkg::AND;
                    3'b110:  alu_op_o = rvseed_isa_pkg::OR;
                    3'b100:  alu_op_o = rvseed_isa_pkg::XOR;
                    3'b001:  alu_op_o = rvseed_isa_pkg::SLL;
                    3'b101:  alu_op_o = rvseed_isa_pkg::SRL;
                    default: unknown_o = 1'b1;  // slti, sltiu
                endcase
                if (funct3[1:0] == 2'b01 && funct7[6:1] != '0)
                    unknown_o = 1'b1;  // srai or malformed shift
            end
            rvseed_isa_pkg::OP: begin
                wen_o = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op_o = rvseed_isa_pkg::ADD;
                    10'b0100000_000: alu_op_o = rvseed_isa_pkg::SUB;
                    10'b0000000_111: alu_op_o = rvseed_isa_pkg::AND;
                    10'b0000000_110: alu_op_o = rvseed_isa_pkg::OR;
                    10'b0000000_100: alu_op_o = rvseed_isa_pkg::XOR;
                    default:         unknown_o = 1'b1;
                endcase
            end
            rvseed_isa_pkg::LUI: begin
                alu_op_o = rvseed_isa_pkg::PASS_B;
                src2_o   = imm_u;
                wen_o    = 1'b1;
            end
            rvseed_isa_pkg::BRANCH: begin
                is_branch = (funct3[2:1] == 2'b00);  // beq, bne
                unknown_o = !is_branch;
            end
            rvseed_isa_pkg::JAL: begin
                alu_op_o = rvseed_isa_pkg::PASS_B;
                src2_o   = pc_i + `CPU_WIDTH'd4;  // link value
                wen_o    = 1'b1;
                is_jal   = 1'b1;
            end
            rvseed_isa_pkg::SYSTEM: begin
                ebreak_o  = (inst_i == 32'h0010_0073);
                unknown_o = !ebreak_o;
            end
            default: unknown_o = 1'b1;
        endcase
        if (unknown_o)
            wen_o = 1'b0;  // retired as a no-op
    end

    assign taken       = is_branch && (funct3[0] ? rs1_val != rs2_val : rs1_val == rs2_val);
    assign redirect_o  = valid_i && (is_jal || taken);
    assign next_pc_o   = pc_i + (is_jal ? imm_j : imm_b);
    assign halt_req_o  = valid_i && ebreak_o;
    assign src1_o      = rs1_val;
    assign rd_o        = inst_i[11:7];
    assign valid_o     = valid_i;
    assign rf_raddr1_o = rs1;
    assign rf_raddr2_o = rs2;

endmodule

// File: verilog/if_id_regs.sv
// rvseed fetch to decode register
`timescale 1ns/100ps
`include "rvseed_settings.svh"

module if_id_regs (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [`CPU_WIDTH-1:0] pc_i,
    input  logic [31:0]           inst_i,
    input  logic                  valid_i,
    input  logic                  flush_i,
    output logic [`CPU_WIDTH-1:0] pc_o,
    output logic [31:0]           inst_o,
    output logic                  valid_o
);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            valid_o <= 1'b0;
        else
            valid_o <= valid_i && !flush_i;  // wrong-path fetch becomes a bubble
    end

    always_ff @(posedge clk) begin
        pc_o   <= pc_i;
        inst_o <= inst_i;
    end

endmodule

// File: verilog/if_stage.sv
// rvseed fetch stage
`timescale 1ns/100ps
`include "rvseed_settings.svh"

module if_stage (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  redirect_i,
    input  logic [`CPU_WIDTH-1:0] next_pc_i,
    input  logic                  halt_req_i,
    output logic [`CPU_WIDTH-1:0] imem_addr_o,
    output logic                  fetch_valid_o
);

    logic [`CPU_WIDTH-1:0]          pc_r;
    rvseed_pipe_pkg::fetch_state_e state_r;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_r    <= `RESET_PC;
            state_r <= rvseed_pipe_pkg::RUN;
        end else begin
            if (halt_req_i)
                state_r <= rvseed_pipe_pkg::HALTED;  // sticky until reset
            if (redirect_i)
                pc_r <= next_pc_i;  // taken branch or jal
            else if (fetch_valid_o)
                pc_r <= pc_r + `CPU_WIDTH'd4;
        end
    end

    assign imem_addr_o = pc_r;

    // the word fetched beside a decoding ebreak is already dead
    assign fetch_valid_o = (state_r == rvseed_pipe_pkg::RUN) && !halt_req_i;

endmodule

// File: verilog/rvseed_isa_pkg.sv
// rvseed instruction set types
package rvseed_isa_pkg;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,  // addi andi ori xori slli srli
        OP     = 7'b0110011,  // add sub and or xor
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,  // beq bne
        JAL    = 7'b1101111,
        SYSTEM = 7'b1110011   // ebreak only
    } opcode_e;

    // operations of the execute stage ALU
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,     // shift amount from src2[5:0]
        SRL,
        PASS_B   // lui and jal link value
    } alu_op_e;

endpackage

// File: verilog/rvseed_pipe_pkg.sv
// rvseed pipeline control types
package rvseed_pipe_pkg;

    typedef enum logic {
        RUN,
        HALTED   // ebreak seen, no more fetches
    } fetch_state_e;

    // where a decode operand comes from
    typedef enum logic [1:0] {
        REGFILE,
        FROM_EX,   // ALU output of the execute stage
        FROM_WB    // result held in writeback
    } bypass_e;

endpackage

// File: verilog/rvseed_settings.svh
// rvseed core settings
`ifndef RVSEED_SETTINGS_SVH
`define RVSEED_SETTINGS_SVH

`define CPU_WIDTH      64     // data path width
`define REG_ADDR_WIDTH 5      // register index width
`define REG_DATA_DEPTH 32     // integer registers
`define RESET_PC       64'h0  // first fetch address

`endif

// File: verilog/rvseed_top.sv
// rvseed core top level
`timescale 1ns/100ps
`include "rvseed_settings.svh"

module rvseed_top (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic [31:0]                imem_data_i,
    output logic [`CPU_WIDTH-1:0]      imem_addr_o,
    output logic                       retire_valid_o,
    output logic [`CPU_WIDTH-1:0]      retire_pc_o,
    output logic [`REG_ADDR_WIDTH-1:0] retire_rd_o,
    output logic [`CPU_WIDTH-1:0]      retire_data_o,
    output logic                       retire_wen_o,
    output logic                       unknown_o,
    output logic [31:0]                unknown_code_o,
    output logic                       halted_o
);

    logic                       if_valid, id_valid, dec_valid, ex_valid;
    logic                       redirect, halt_req;
    logic [`CPU_WIDTH-1:0]      next_pc, id_pc, ex_pc, ex_result;
    logic [31:0]                id_inst, ex_inst;
    logic [`REG_ADDR_WIDTH-1:0] rf_raddr1, rf_raddr2, id_rd, ex_rd;
    logic [`CPU_WIDTH-1:0]      rf_rdata1, rf_rdata2;
    logic [`CPU_WIDTH-1:0]      id_src1, id_src2, ex_src1, ex_src2;
    logic                       id_wen, id_ebreak, id_unknown;
    logic                       ex_wen, ex_ebreak, ex_unknown;
    rvseed_isa_pkg::alu_op_e    id_alu_op, ex_alu_op;

    if_stage u_if_stage (
        .clk(clk), .rst_n_i(rst_n_i),
        .redirect_i(redirect), .next_pc_i(next_pc), .halt_req_i(halt_req),
        .imem_addr_o(imem_addr_o), .fetch_valid_o(if_valid)
    );

    if_id_regs u_if_id_regs (
        .clk(clk), .rst_n_i(rst_n_i),
        .pc_i(imem_addr_o), .inst_i(imem_data_i), .valid_i(if_valid),
        .flush_i(redirect),
        .pc_o(id_pc), .inst_o(id_inst), .valid_o(id_valid)
    );

    id_stage u_id_stage (
        .pc_i(id_pc), .inst_i(id_inst), .valid_i(id_valid),
        .ex_valid_i(ex_valid), .ex_wen_i(ex_wen), .ex_rd_i(ex_rd),
        .ex_result_i(ex_result),
        .wb_valid_i(retire_valid_o), .wb_wen_i(retire_wen_o), .wb_rd_i(retire_rd_o),
        .wb_data_i(retire_data_o),
        .rf_rdata1_i(rf_rdata1), .rf_rdata2_i(rf_rdata2),
        .rf_raddr1_o(rf_raddr1), .rf_raddr2_o(rf_raddr2),
        .alu_op_o(id_alu_op), .src1_o(id_src1), .src2_o(id_src2),
        .rd_o(id_rd), .wen_o(id_wen), .valid_o(dec_valid),
        .ebreak_o(id_ebreak), .unknown_o(id_unknown),
        .redirect_o(redirect), .next_pc_o(next_pc), .halt_req_o(halt_req)
    );

    id_ex_regs u_id_ex_regs (
        .clk(clk), .rst_n_i(rst_n_i),
        .valid_i(dec_valid), .pc_i(id_pc), .alu_op_i(id_alu_op),
        .src1_i(id_src1), .src2_i(id_src2), .rd_i(id_rd), .wen_i(id_wen),
        .ebreak_i(id_ebreak), .unknown_i(id_unknown), .inst_i(id_inst),
        .valid_o(ex_valid), .pc_o(ex_pc), .alu_op_o(ex_alu_op),
        .src1_o(ex_src1), .src2_o(ex_src2), .rd_o(ex_rd), .wen_o(ex_wen),
        .ebreak_o(ex_ebreak), .unknown_o(ex_unknown), .inst_o(ex_inst)
    );

    ex_stage u_ex_stage (
        .alu_op_i(ex_alu_op), .src1_i(ex_src1), .src2_i(ex_src2),
        .result_o(ex_result)
    );

    wb_stage u_wb_stage (
        .clk(clk), .rst_n_i(rst_n_i),
        .valid_i(ex_valid), .pc_i(ex_pc), .result_i(ex_result), .rd_i(ex_rd),
        .wen_i(ex_wen), .ebreak_i(ex_ebreak), .unknown_i(ex_unknown), .inst_i(ex_inst),
        .raddr1_i(rf_raddr1), .raddr2_i(rf_raddr2),
        .rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2),
        .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
        .retire_rd_o(retire_rd_o), .retire_data_o(retire_data_o),
        .retire_wen_o(retire_wen_o), .unknown_o(unknown_o),
        .unknown_code_o(unknown_code_o), .halted_o(halted_o)
    );

endmodule

// File: verilog/wb_stage.sv
// rvseed writeback stage and register file
`timescale 1ns/100ps
`include "rvseed_settings.svh"

module wb_stage (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       valid_i,
    input  logic [`CPU_WIDTH-1:0]      pc_i,
    input  logic [`CPU_WIDTH-1:0]      result_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rd_i,
    input  logic                       wen_i,
    input  logic                       ebreak_i,
    input  logic                       unknown_i,
    input  logic [31:0]                inst_i,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr1_i,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr2_i,
    output logic [`CPU_WIDTH-1:0]      rdata1_o,
    output logic [`CPU_WIDTH-1:0]      rdata2_o,
    output logic                       retire_valid_o,
    output logic [`CPU_WIDTH-1:0]      retire_pc_o,
    output logic [`REG_ADDR_WIDTH-1:0] retire_rd_o,
    output logic [`CPU_WIDTH-1:0]      retire_data_o,
    output logic                       retire_wen_o,
    output logic                       unknown_o,
    output logic [31:0]                unknown_code_o,
    output logic                       halted_o
);

    logic                  wen_r, ebreak_r, unknown_r, halted_r;
    logic [`CPU_WIDTH-1:0] regs [0:`REG_DATA_DEPTH-1];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            retire_valid_o <= 1'b0;
            halted_r       <= 1'b0;
        end else begin
            retire_valid_o <= valid_i;
            if (retire_valid_o && ebreak_r)
                halted_r <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        retire_pc_o    <= pc_i;
        retire_data_o  <= result_i;
        retire_rd_o    <= rd_i;
        wen_r          <= wen_i;
        ebreak_r       <= ebreak_i;
        unknown_r      <= unknown_i;
        unknown_code_o <= inst_i;
    end

    // written on the edge that closes the writeback cycle
    always_ff @(posedge clk) begin
        if (retire_wen_o)
            regs[retire_rd_o] <= retire_data_o;
    end

    assign retire_wen_o = retire_valid_o && wen_r && (retire_rd_o != '0);  // x0 stays zero
    assign unknown_o    = retire_valid_o && unknown_r;
    assign halted_o     = halted_r || (retire_valid_o && ebreak_r);  // up with the ebreak
    assign rdata1_o     = regs[raddr1_i];
    assign rdata2_o     = regs[raddr2_i];

endmodule

// File: vlog.f
+incdir+verilog
verilog/rvseed_isa_pkg.sv
verilog/rvseed_pipe_pkg.sv
verilog/if_stage.sv
verilog/if_id_regs.sv
verilog/id_stage.sv
verilog/id_ex_regs.sv
verilog/ex_stage.sv
verilog/wb_stage.sv
verilog/rvseed_top.sv
tests/rvseed_assertions.sv
tests/rvseed_tb.sv
